// File: riscv_pkg.sv
// shared definitions for the single-cycle rv32i core
// widths, opcodes, function codes, control enums and instruction formats
`default_nettype none

package riscv_pkg;

	// data and address width, rv32 only
	localparam int unsigned xlen = 32;

	typedef logic [4:0] reg_idx_t;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011
	} opcode_e;

	// funct3 for op and op-imm
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct3 for branches, 010 and 011 are unused
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
	} alu_op_e;

	typedef enum logic {src_a_reg, src_a_pc} src_a_e;
	typedef enum logic {src_b_reg, src_b_imm} src_b_e;
	typedef enum logic [1:0] {flow_seq, flow_branch, flow_jal, flow_jalr} flow_e;
	typedef enum logic {wb_alu, wb_pc4} wb_sel_e;

	// one struct per base format, msb first
	typedef struct packed {
		logic [6:0] funct7; reg_idx_t rs2; reg_idx_t rs1;
		logic [2:0] funct3; reg_idx_t rd; logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0; reg_idx_t rs1;
		logic [2:0] funct3; reg_idx_t rd; logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5; reg_idx_t rs2; reg_idx_t rs1;
		logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12; logic [5:0] imm_10_5; reg_idx_t rs2; reg_idx_t rs1;
		logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12; reg_idx_t rd; logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20; logic [9:0] imm_10_1; logic imm_11;
		logic [7:0] imm_19_12; reg_idx_t rd; logic [6:0] opcode;
	} j_fmt_t;

	// same 32-bit word seen through each format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

endpackage

`default_nettype wire

// File: pc_unit.sv
// program counter
// holds pc and picks the next fetch address from the control flow kind
`default_nettype none

module pc_unit
	import riscv_pkg::*;
#(
	parameter logic [31:0] reset_pc = 32'h0
) (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire flow_e           flow,
	input  wire logic            branch_taken,
	input  wire logic [xlen-1:0] imm,
	input  wire logic [xlen-1:0] rs1_val,
	output logic      [xlen-1:0] pc
);

	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_rel;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] pc_next;

	assign pc_plus4 = pc + 32'd4;

	// branch and jal targets share one adder
	assign pc_rel = pc + imm;

	// jalr is register relative
	assign jalr_sum = rs1_val + imm;

	always_comb begin
		case (flow)
			flow_branch: begin
				// untaken falls through
				pc_next = branch_taken ? pc_rel : pc_plus4;
			end
			flow_jal: begin
				pc_next = pc_rel;
			end
			flow_jalr: begin
				// lsb of target forced to zero
				pc_next = {jalr_sum[xlen-1:1], 1'b0};
			end
			default: begin
				pc_next = pc_plus4;
			end
		endcase
	end

	// one instruction per edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// File: inst_decode.sv
// instruction field decode
// pulls register indices, function bits and the sign-extended immediate
`default_nettype none

module inst_decode
	import riscv_pkg::*;
(
	input  wire inst_u           inst,
	output opcode_e              opcode,
	output logic      [2:0]      funct3,
	output logic                 funct7_b5,
	output reg_idx_t             rs1,
	output reg_idx_t             rs2,
	output reg_idx_t             rd,
	output logic      [xlen-1:0] imm
);

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	// opcode sits at the bottom of every format
	assign opcode = opcode_e'(inst.r_fmt.opcode);

	// funct3 and rs1 share one slot in r, i, s and b
	assign funct3 = inst.r_fmt.funct3;
	assign rs1    = inst.r_fmt.rs1;

	// rs2 slot is common to r, s and b
	assign rs2 = inst.s_fmt.rs2;

	// rd slot is common to r, i, u and j
	assign rd = inst.u_fmt.rd;

	// bit 30 picks sub and sra
	assign funct7_b5 = inst.r_fmt.funct7[5];

	// i-type, shamt ends up in imm[4:0]
	assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};

	// b-type, scrambled offset in units of 2 bytes
	assign imm_b = {
		{19{inst.b_fmt.imm_12}},
		inst.b_fmt.imm_12,
		inst.b_fmt.imm_11,
		inst.b_fmt.imm_10_5,
		inst.b_fmt.imm_4_1,
		1'b0
	};

	// u-type, upper 20 bits
	assign imm_u = {inst.u_fmt.imm_31_12, 12'h000};

	// j-type
	assign imm_j = {
		{11{inst.j_fmt.imm_20}},
		inst.j_fmt.imm_20,
		inst.j_fmt.imm_19_12,
		inst.j_fmt.imm_11,
		inst.j_fmt.imm_10_1,
		1'b0
	};

	// format chosen by opcode
	always_comb begin
		case (opcode)
			opc_op_imm, opc_jalr: begin
				imm = imm_i;
			end
			opc_branch: begin
				imm = imm_b;
			end
			opc_lui, opc_auipc: begin
				imm = imm_u;
			end
			opc_jal: begin
				imm = imm_j;
			end
			default: begin
				// register ops carry no immediate
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: control_unit.sv
// main control
// maps opcode and function bits onto datapath selects and the illegal flag
`default_nettype none

module control_unit
	import riscv_pkg::*;
(
	input  wire opcode_e    opcode,
	input  wire logic [2:0] funct3,
	input  wire logic       funct7_b5,
	output alu_op_e         alu_op,
	output src_a_e          src_a,
	output src_b_e          src_b,
	output logic            reg_write,
	output flow_e           flow,
	output wb_sel_e         wb_sel,
	output logic            illegal
);

	// shared alu decode for op and op-imm
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			f3_add_sub: op = alt ? alu_sub : alu_add;
			f3_sll:     op = alu_sll;
			f3_slt:     op = alu_slt;
			f3_sltu:    op = alu_sltu;
			f3_xor:     op = alu_xor;
			f3_srl_sra: op = alt ? alu_sra : alu_srl;
			f3_or:      op = alu_or;
			default:    op = alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		// defaults give a no-op
		alu_op    = alu_add;
		src_a     = src_a_reg;
		src_b     = src_b_reg;
		reg_write = 1'b0;
		flow      = flow_seq;
		wb_sel    = wb_alu;
		illegal   = 1'b0;

		case (opcode)
			opc_op: begin
				alu_op    = arith_op(funct3, funct7_b5);
				reg_write = 1'b1;
			end
			opc_op_imm: begin
				// bit 30 is immediate data except on right shifts
				alu_op    = arith_op(funct3, funct7_b5 && (funct3 == f3_srl_sra));
				src_b     = src_b_imm;
				reg_write = 1'b1;
			end
			opc_lui: begin
				alu_op    = alu_pass_b;
				src_b     = src_b_imm;
				reg_write = 1'b1;
			end
			opc_auipc: begin
				src_a     = src_a_pc;
				src_b     = src_b_imm;
				reg_write = 1'b1;
			end
			opc_jal: begin
				flow      = flow_jal;
				wb_sel    = wb_pc4;
				reg_write = 1'b1;
			end
			opc_jalr: begin
				flow      = flow_jalr;
				wb_sel    = wb_pc4;
				reg_write = 1'b1;
			end
			opc_branch: begin
				// operands stay on rs1/rs2 for the compare
				if (funct3 == 3'b010 || funct3 == 3'b011) begin
					illegal = 1'b1;
				end else begin
					flow = flow_branch;
				end
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: reg_file.sv
// integer register file
// x1..x31 with two async read ports and one write port, x0 hardwired to zero
`default_nettype none

module reg_file
	import riscv_pkg::*;
(
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            we,
	input  wire reg_idx_t        waddr,
	input  wire reg_idx_t        raddr1,
	input  wire reg_idx_t        raddr2,
	input  wire logic [xlen-1:0] wdata,
	output logic      [xlen-1:0] rdata1,
	output logic      [xlen-1:0] rdata2
);

	// no storage for x0
	logic [xlen-1:0] regs [1:31];

	// reads bypass nothing, a write lands at the edge
	always_comb begin
		if (raddr1 == 5'd0) begin
			rdata1 = '0;
		end else begin
			rdata1 = regs[raddr1];
		end
	end

	always_comb begin
		if (raddr2 == 5'd0) begin
			rdata2 = '0;
		end else begin
			rdata2 = regs[raddr2];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			// writes to x0 dropped here
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: alu.sv
// integer alu
// arithmetic, logic, shifts, set-less-than and the branch compare
`default_nettype none

module alu
	import riscv_pkg::*;
(
	input  wire alu_op_e         op,
	input  wire logic [xlen-1:0] a,
	input  wire logic [xlen-1:0] b,
	input  wire logic [2:0]      branch_func,
	output logic      [xlen-1:0] result,
	output logic                 branch_taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       eq;

	// only the low 5 bits shift
	assign shamt = b[4:0];

	// compares shared by slt and branches
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq   = a == b;

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
			alu_sll:    result = a << shamt;
			alu_srl:    result = a >> shamt;
			// arithmetic shift keeps the sign
			alu_sra:    result = $unsigned($signed(a) >>> shamt);
			alu_pass_b: result = b;
			default:    result = a + b;
		endcase
	end

	// condition only, pc_unit looks at it for branches alone
	always_comb begin
		case (branch_func)
			f3_beq:  branch_taken = eq;
			f3_bne:  branch_taken = !eq;
			f3_blt:  branch_taken = lt_s;
			f3_bge:  branch_taken = !lt_s;
			f3_bltu: branch_taken = lt_u;
			f3_bgeu: branch_taken = !lt_u;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: core_top.sv
// single-cycle rv32i core
// fetch by pc, decode, execute and write back in one cycle with a retire port
`default_nettype none

module core_top
	import riscv_pkg::*;
#(
	parameter logic [31:0] reset_pc = 32'h0
) (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic [xlen-1:0] inst,
	output logic      [xlen-1:0] pc,
	output logic                 wb_en,
	output reg_idx_t             wb_rd,
	output logic      [xlen-1:0] wb_data,
	output logic                 illegal
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            funct7_b5;
	reg_idx_t        rs1;
	reg_idx_t        rs2;
	reg_idx_t        rd;
	logic [xlen-1:0] imm;
	alu_op_e         alu_op;
	src_a_e          src_a;
	src_b_e          src_b;
	logic            reg_write;
	flow_e           flow;
	wb_sel_e         wb_sel;
	logic            dec_illegal;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;
	logic            branch_taken;
	logic [xlen-1:0] pc_plus4;

	pc_unit #(.reset_pc(reset_pc)) pc_unit_i (
		.clk(clk), .rst_n(rst_n), .flow(flow), .branch_taken(branch_taken),
		.imm(imm), .rs1_val(rdata1), .pc(pc)
	);

	inst_decode inst_decode_i (
		.inst(inst), .opcode(opcode), .funct3(funct3), .funct7_b5(funct7_b5),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm)
	);

	control_unit control_unit_i (
		.opcode(opcode), .funct3(funct3), .funct7_b5(funct7_b5), .alu_op(alu_op),
		.src_a(src_a), .src_b(src_b), .reg_write(reg_write), .flow(flow),
		.wb_sel(wb_sel), .illegal(dec_illegal)
	);

	// write side shares the retire signals
	reg_file reg_file_i (
		.clk(clk), .rst_n(rst_n), .we(wb_en), .waddr(wb_rd), .raddr1(rs1),
		.raddr2(rs2), .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
	);

	// branches keep both selects on the register side, so the compare sees rs1/rs2
	assign alu_a = (src_a == src_a_pc) ? pc : rdata1;
	assign alu_b = (src_b == src_b_imm) ? imm : rdata2;

	alu alu_i (
		.op(alu_op), .a(alu_a), .b(alu_b), .branch_func(funct3),
		.result(alu_result), .branch_taken(branch_taken)
	);

	// link value for jal and jalr
	assign pc_plus4 = pc + 32'd4;

	// retire port, quiet while in reset
	assign wb_en   = reg_write && rst_n;
	assign wb_rd   = rd;
	assign wb_data = (wb_sel == wb_pc4) ? pc_plus4 : alu_result;
	assign illegal = dec_illegal && rst_n;

endmodule

`default_nettype wire

// File: tb_core_top.sv
// testbench for the single-cycle rv32i core
// feeds a program image by pc and checks the retire trace every cycle
`default_nettype none

module tb_core_top;

	localparam int image_words  = 64;
	localparam int trace_base   = 64;
	localparam int rec_words    = 6;
	localparam int mem_words    = 512;
	localparam int reset_cycles = 10;

	logic        clk;
	logic        rst_n;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        wb_en;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        illegal;

	// program image first then trace records from word 64
	logic [31:0] pat [0:mem_words-1];

	int          n_records;
	int          cycle_limit;
	int          cycles;
	int          errors;
	int          test_errors;
	int          tests_done;
	int          checks;

	core_top #(.reset_pc(32'h0)) dut_i (
		.clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .wb_en(wb_en),
		.wb_rd(wb_rd), .wb_data(wb_data), .illegal(illegal)
	);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// counts cycles out of reset
	always @(posedge clk) begin
		if (rst_n) begin
			cycles = cycles + 1;
			if (cycles > cycle_limit) begin
				$display("Checks failed");
				$display("timeout: the trace did not finish within %0d cycles", cycle_limit);
				$finish;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("mismatch at %0t: %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	function automatic string test_name(input int id);
		string name;
		case (id)
			1: name = "reset state";
			2: name = "alu operations";
			3: name = "branches";
			4: name = "jal and jalr";
			5: name = "illegal opcode";
			default: name = "unknown";
		endcase
		return name;
	endfunction

	task automatic finish_test(input int id);
		tests_done++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok", id, test_name(id));
		end else begin
			$display("test %0d %s: %0d errors", id, test_name(id), test_errors);
		end
		test_errors = 0;
	endtask

	// word at the current pc with the image wrapping at 64 words
	task automatic feed_inst();
		inst = pat[pc[7:2]];
	endtask

	task automatic load_patterns();
		int i;
		for (i = 0; i < mem_words; i++) begin
			pat[i] = 32'h0;
		end
		$readmemh("core_patterns.txt", pat);
		// holes get random words whose low bits 00 match no valid opcode
		for (i = 0; i < image_words; i++) begin
			if (pat[i] == 32'h0) begin
				pat[i] = $urandom() & 32'hffff_fffc;
			end
		end
		// trace ends at test id ff
		n_records = 0;
		while (trace_base + rec_words * (n_records + 1) <= mem_words &&
			pat[trace_base + rec_words * n_records] != 32'hff) begin
			n_records++;
		end
	endtask

	initial begin
		int r;
		int base;
		int cur_test;
		void'($urandom(32'h6c42));
		rst_n       = 1'b0;
		inst        = 32'h0;
		errors      = 0;
		test_errors = 0;
		tests_done  = 0;
		checks      = 0;
		cycles      = 0;
		cycle_limit = 20;
		cur_test    = 0;
		load_patterns();
		cycle_limit = n_records + 20;
		if (n_records == 0) begin
			errors++;
			$display("no trace records were found in core_patterns.txt");
		end

		// first word is presented once reset has loaded pc
		repeat (reset_cycles - 1) begin
			@(posedge clk);
			#1;
			feed_inst();
		end
		#2;
		check("pc", pc, 32'h0);
		check("wb_en", wb_en, 1'b0);
		check("illegal", illegal, 1'b0);
		finish_test(1);

		@(posedge clk);
		#1;
		rst_n = 1'b1;
		feed_inst();

		// one record per retired instruction
		for (r = 0; r < n_records; r++) begin
			base = trace_base + rec_words * r;
			if (r > 0 && pat[base] != cur_test) begin
				finish_test(cur_test);
			end
			cur_test = pat[base];
			// sample just before the edge
			#2;
			check("pc", pc, pat[base + 1]);
			check("wb_en", wb_en, pat[base + 2]);
			if (pat[base + 2][0]) begin
				check("wb_rd", wb_rd, pat[base + 3]);
				check("wb_data", wb_data, pat[base + 4]);
			end
			check("illegal", illegal, pat[base + 5]);
			@(posedge clk);
			#1;
			feed_inst();
		end
		if (n_records > 0) begin
			finish_test(cur_test);
		end

		$display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: core_patterns.txt
// words 00..3f: program image, unlisted words become random illegal opcodes
// from @40 one record per cycle: test pc wb_en wb_rd wb_data illegal, test ff ends
@00 ffb00093 00700113 402081b3 4021d233 // addi x1 -5, addi x2 7, sub x3, sra x4
@04 4010d293 0020a333 0020b3b3 12345437 // srai x5, slt x6, sltu x7, lui x8
@08 00001497 00110013 00200533 00a10463 // auipc x9, addi x0, add x10, beq taken
@0d 00208463 00209463 // beq not taken, bne taken
@10 00a11463 0020c463 // bne not taken, blt taken
@13 00114463 00115463 // blt not taken, bge taken
@16 0020d463 00116463 // bge not taken, bltu taken
@19 0020e463 0020f463 // bltu not taken, bgeu taken
@1c 00117463 00c005ef // bgeu not taken, jal x11 +12
@20 019586e7 // jalr x13 x11 0x19
@26 00300713 // addi x14 3 after two illegal words
@40
02 00000000 1 01 fffffffb 0
02 00000004 1 02 00000007 0
02 00000008 1 03 fffffff4 0
02 0000000c 1 04 ffffffff 0
02 00000010 1 05 fffffffd 0
02 00000014 1 06 00000001 0
02 00000018 1 07 00000000 0
02 0000001c 1 08 12345000 0
02 00000020 1 09 00001020 0
02 00000024 1 00 00000008 0
02 00000028 1 0a 00000007 0
03 0000002c 0 00 00000000 0
03 00000034 0 00 00000000 0
03 00000038 0 00 00000000 0
03 00000040 0 00 00000000 0
03 00000044 0 00 00000000 0
03 0000004c 0 00 00000000 0
03 00000050 0 00 00000000 0
03 00000058 0 00 00000000 0
03 0000005c 0 00 00000000 0
03 00000064 0 00 00000000 0
03 00000068 0 00 00000000 0
03 00000070 0 00 00000000 0
04 00000074 1 0b 00000078 0
04 00000080 1 0d 00000084 0
05 00000090 0 00 00000000 1
05 00000094 0 00 00000000 1
05 00000098 1 0e 00000003 0
ff 00000000 0 00 00000000 0

// File: filelist.f
riscv_pkg.sv
pc_unit.sv
inst_decode.sv
control_unit.sv
reg_file.sv
alu.sv
core_top.sv
tb_core_top.sv

// File: Bender.yml
package:
  name: rv32i_single_cycle

sources:
  - riscv_pkg.sv
  - pc_unit.sv
  - inst_decode.sv
  - control_unit.sv
  - reg_file.sv
  - alu.sv
  - core_top.sv
  - target: test
    files:
      - tb_core_top.sv
